// File: compile.f
+incdir+verilog
verilog/dcache_geom_pkg.sv
verilog/dcache_mem_pkg.sv
verilog/miss_if.sv
verilog/miss_port_arbiter.sv
verilog/refill_mshr.sv
verilog/miss_ctrl_fsm.sv
verilog/dcache_missunit.sv
test/tb_dcache_missunit.sv

// File: Bender.yml
package:
  name: dcache_missunit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_geom_pkg.sv
      - verilog/dcache_mem_pkg.sv
      - verilog/miss_if.sv
      - verilog/miss_port_arbiter.sv
      - verilog/refill_mshr.sv
      - verilog/miss_ctrl_fsm.sv
      - verilog/dcache_missunit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_dcache_missunit.sv

// File: test/tb_dcache_missunit.sv
`default_nettype none
`include "dcache_defs.svh"

module tb_dcache_missunit;
  import dcache_geom_pkg::*;
  import dcache_mem_pkg::*;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP       = `DCACHE_NUM_PORTS;
  // event counters: acks per port, returns per port, sweeps, flush acks, sweep writes
  localparam int EV_ACK   = 0;
  localparam int EV_RTRN  = 3;
  localparam int EV_SWEEP = 6;
  localparam int EV_FACK  = 7;
  localparam int EV_FWR   = 8;

  logic clk_i, rst_ni, flush_i, flush_ack_o, miss_o, wbuffer_empty_i;
  logic [NP-1:0] miss_req_i, miss_ack_o, miss_nc_i, miss_we_i, miss_rtrn_vld_o;
  logic [NP-1:0][63:0] miss_wdata_i;
  paddr_t  [NP-1:0] miss_paddr_i;
  way_oh_t [NP-1:0] miss_vld_bits_i;
  size_t   [NP-1:0] miss_size_i;
  tid_t    [NP-1:0] miss_id_i;
  tid_t      miss_rtrn_id_o;
  logic      wr_cl_vld_o, wr_cl_nc_o;
  way_oh_t   wr_cl_we_o, wr_vld_bits_o;
  tag_t      wr_cl_tag_o;
  set_idx_t  wr_cl_idx_o;
  offset_t   wr_cl_off_o;
  line_t     wr_cl_data_o;
  logic      mem_rtrn_vld_i, mem_req_o, mem_ack_i;
  mem_rtrn_t mem_rtrn_i;
  mem_req_t  mem_data_o;

  // memory model and monitor state
  int         cyc, ack_wait, last_due, sweep_idx, rd_port;
  int         ev_cnt[9];
  logic       req_waiting, rd_busy, rd_nc, flush_asked;
  paddr_t     rd_paddr;
  tid_t       rd_id;
  way_t       rd_way;
  int         rtrn_due[$];
  rtrn_type_e rtrn_kind[$];
  tid_t       rtrn_tid[$];
  paddr_t     rtrn_addr[$];

  dcache_missunit uut (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // reference model

  // line content seen by memory, built from the line address
  function automatic line_t line_of(input paddr_t paddr);
    paddr_t la;
    la = {paddr[`DCACHE_PADDR_WIDTH-1:`DCACHE_OFFSET_WIDTH], {`DCACHE_OFFSET_WIDTH{1'b0}}};
    return {la ^ 32'h5a5a_0f0f, ~la, la + 32'h1357_9bdf, {la[15:0], la[31:16]}};
  endfunction

  // drop the address bits below 2**size bytes
  function automatic paddr_t align_ref(input paddr_t paddr, input size_t size);
    paddr_t mask;
    mask = '1;
    if (size <= 3'd3) begin
      mask = ~((32'd1 << size) - 32'd1);
    end
    return paddr & mask;
  endfunction

  // lowest way with a clear valid bit, -1 when the set is full
  function automatic int first_free_way(input way_oh_t vbits);
    for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
      if (!vbits[w]) begin
        return w;
      end
    end
    return -1;
  endfunction

  ////////////////////////////////////////////////////////////
  // failure helpers

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED @ %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("error @ %0t ns: %s", $time, why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic await_count(input int sel, input int target, input string what);
    int n;
    n = 0;
    while (ev_cnt[sel] < target) begin
      @(negedge clk_i);
      n++;
      if (n > 200) begin
        abort_run({"timed out waiting for ", what});
      end
    end
  endtask

  // put a miss on port p, the last port always stores
  task automatic raise_miss(input int p, input logic nc, input paddr_t paddr, input size_t size,
                            input tid_t id, input way_oh_t vbits, input logic [63:0] wdata);
    miss_we_i[p]       = (p == NP-1);
    miss_nc_i[p]       = nc;
    miss_paddr_i[p]    = paddr;
    miss_size_i[p]     = size;
    miss_id_i[p]       = id;
    miss_vld_bits_i[p] = vbits;
    miss_wdata_i[p]    = wdata;
    miss_req_i[p]      = 1'b1;
  endtask

  task automatic release_after_ack(input int p, input int target);
    await_count(EV_ACK + p, target, "miss ack");
    miss_req_i[p] = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // memory model, drives on the falling edge

  always @(negedge clk_i) begin : mem_drive
    if (rst_ni) begin
      // ack after ack_wait cycles of a pending request
      if (req_waiting) begin
        if (ack_wait == 0) begin
          mem_ack_i = 1'b1;
        end else begin
          ack_wait = ack_wait - 1;
        end
      end else begin
        mem_ack_i = 1'b0;
      end
      mem_rtrn_vld_i = 1'b0;
      if (rtrn_due.size() > 0 && rtrn_due[0] <= cyc) begin
        void'(rtrn_due.pop_front());
        mem_rtrn_vld_i   = 1'b1;
        mem_rtrn_i.rtype = rtrn_kind.pop_front();
        mem_rtrn_i.tid   = rtrn_tid.pop_front();
        mem_rtrn_i.data  = line_of(rtrn_addr.pop_front());
        if (mem_rtrn_i.rtype == RTRN_STORE_ACK) begin
          mem_rtrn_i.data = '0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // compare, samples on the rising edge

  always @(posedge clk_i) begin : compare_proc
    logic     cl_write, load_rtrn, xfer;
    int       p, exp_port, free, due;
    mem_req_t exp_req;
    if (rst_ni) begin
      cyc         = cyc + 1;
      cl_write    = wr_cl_vld_o && (wr_cl_we_o != '0);
      load_rtrn   = mem_rtrn_vld_i && (mem_rtrn_i.rtype == RTRN_LOAD_ACK);
      xfer        = mem_req_o && mem_ack_i;
      req_waiting = mem_req_o && !mem_ack_i;

      // return pulses and refill writes
      if (load_rtrn) begin
        check(miss_rtrn_vld_o, 3'b001 << rd_port, "load return port");
        check(miss_rtrn_id_o, rd_id, "load return id");
        check(cl_write, !rd_nc, "refill write present");
        check(wr_cl_nc_o, rd_nc, "refill non-cacheable flag");
        if (!rd_nc) begin
          check(wr_cl_idx_o, rd_paddr[`DCACHE_OFFSET_WIDTH +: `DCACHE_INDEX_WIDTH], "refill index");
          check(wr_cl_tag_o, rd_paddr[`DCACHE_PADDR_WIDTH-1 -: `DCACHE_TAG_WIDTH], "refill tag");
          check(wr_cl_off_o, rd_paddr[`DCACHE_OFFSET_WIDTH-1:0], "refill offset");
          check(wr_cl_data_o, line_of(rd_paddr), "refill data");
          check(wr_cl_we_o, 4'b0001 << rd_way, "refill way enable");
          check(wr_vld_bits_o, 4'b0001 << rd_way, "refill valid bits");
        end
        rd_busy = 1'b0;
        ev_cnt[EV_RTRN + rd_port]++;
      end else if (mem_rtrn_vld_i) begin
        check(miss_rtrn_vld_o, 3'b100, "store ack port");
        ev_cnt[EV_RTRN + NP - 1]++;
      end else begin
        check(miss_rtrn_vld_o, '0, "return pulse without a return");
      end

      // anything else on the write port is a flush sweep
      if (cl_write && !load_rtrn) begin
        check(wr_cl_idx_o, sweep_idx, "flush index");
        check(wr_cl_we_o, 4'hf, "flush way enable");
        check(wr_vld_bits_o, '0, "flush valid bits");
        check(flush_ack_o, (sweep_idx == `DCACHE_NUM_SETS-1) && flush_asked, "flush ack");
        ev_cnt[EV_FWR]++;
        if (sweep_idx == `DCACHE_NUM_SETS-1) begin
          if (flush_asked) begin
            ev_cnt[EV_FACK]++;
          end
          flush_asked = 1'b0;
          sweep_idx   = 0;
          ev_cnt[EV_SWEEP]++;
        end else begin
          sweep_idx++;
        end
      end else begin
        check(flush_ack_o, 1'b0, "flush ack outside a sweep");
        if (sweep_idx != 0) begin
          abort_run("flush sweep stopped before the last set");
        end
      end

      // lowest requesting port, reads blocked while one is outstanding
      exp_port = -1;
      for (p = NP-1; p >= 0; p--) begin
        if (miss_req_i[p] && (p == NP-1 || !rd_busy)) begin
          exp_port = p;
        end
      end
      if (xfer) begin
        if (exp_port < 0) begin
          abort_run("memory request taken with no miss that may be served");
        end
        check(miss_ack_o, 3'b001 << exp_port, "miss ack port");
        free          = first_free_way(miss_vld_bits_i[exp_port]);
        exp_req.rtype = (miss_we_i[exp_port]) ? MEM_STORE_REQ : MEM_LOAD_REQ;
        exp_req.nc    = miss_nc_i[exp_port];
        exp_req.way   = (free < 0 || miss_we_i[exp_port]) ? mem_data_o.way : way_t'(free);
        exp_req.tid   = miss_id_i[exp_port];
        exp_req.size  = miss_size_i[exp_port];
        exp_req.paddr = align_ref(miss_paddr_i[exp_port], miss_size_i[exp_port]);
        exp_req.data  = (miss_we_i[exp_port]) ? miss_wdata_i[exp_port] : mem_data_o.data;
        check(mem_data_o, exp_req, "memory request");
        check(miss_o, !miss_we_i[exp_port] && !miss_nc_i[exp_port], "miss pulse");
        ev_cnt[EV_ACK + exp_port]++;
        if (!miss_we_i[exp_port]) begin
          rd_busy  = 1'b1;
          rd_port  = exp_port;
          rd_paddr = miss_paddr_i[exp_port];
          rd_nc    = miss_nc_i[exp_port];
          rd_id    = miss_id_i[exp_port];
          rd_way   = mem_data_o.way;
        end
        // one return channel, returns leave in request order
        due = cyc + $urandom_range(6, 1);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rtrn_due.push_back(due);
        rtrn_kind.push_back(miss_we_i[exp_port] ? RTRN_STORE_ACK : RTRN_LOAD_ACK);
        rtrn_tid.push_back(mem_data_o.tid);
        rtrn_addr.push_back(mem_data_o.paddr);
        ack_wait = $urandom_range(3, 0);
      end else begin
        check(miss_ack_o, '0, "miss ack without a transfer");
        check(miss_o, 1'b0, "miss pulse without a transfer");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  initial begin : stimulus
    int fwr_before;
    void'($urandom(32'hfd81));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    wbuffer_empty_i = 1'b1;
    {miss_req_i, miss_nc_i, miss_we_i} = '0;
    miss_wdata_i = '0;
    miss_paddr_i = '0;
    miss_vld_bits_i = '0;
    miss_size_i = '0;
    miss_id_i = '0;
    mem_rtrn_vld_i = 1'b0;
    mem_ack_i = 1'b0;
    mem_rtrn_i = '0;
    {cyc, sweep_idx, rd_port, last_due} = '0;
    ack_wait = $urandom_range(3, 0);
    {req_waiting, rd_busy, rd_nc, flush_asked} = '0;
    {rd_paddr, rd_id, rd_way} = '0;
    foreach (ev_cnt[i]) begin
      ev_cnt[i] = 0;
    end

    repeat (8) @(negedge clk_i);
    check({mem_req_o, miss_ack_o, miss_rtrn_vld_o, flush_ack_o, miss_o}, '0, "outputs in reset");
    rst_ni = 1'b1;

    // sweep after reset, no flush ack
    await_count(EV_SWEEP, 1, "reset sweep");
    check(ev_cnt[EV_FWR], `DCACHE_NUM_SETS, "reset sweep length");
    check(ev_cnt[EV_FACK], 0, "flush acks after reset");

    // cacheable read, ways 0 and 1 valid
    raise_miss(0, 1'b0, 32'h1234_567b, 3'd2, 2'd1, 4'b0011, '0);
    release_after_ack(0, 1);
    await_count(EV_RTRN + 0, 1, "cacheable read return");

    // non-cacheable read
    raise_miss(1, 1'b1, 32'h8000_0123, 3'd1, 2'd3, 4'b0000, '0);
    release_after_ack(1, 1);
    await_count(EV_RTRN + 1, 1, "non-cacheable read return");

    // random stores on the write port
    for (int i = 0; i < 4; i++) begin
      raise_miss(NP-1, 1'b0, $urandom, 3'd3, tid_t'(i), '0, {$urandom, $urandom});
      release_after_ack(NP-1, i + 1);
    end
    await_count(EV_RTRN + NP - 1, 4, "store acks");

    // two reads at once, port 0 first, full set on port 1
    raise_miss(0, 1'b0, 32'h0000_0a40, 3'd3, 2'd0, 4'b0111, '0);
    raise_miss(1, 1'b0, 32'hcafe_0f38, 3'd3, 2'd2, 4'b1111, '0);
    release_after_ack(0, 2);
    check(ev_cnt[EV_ACK + 1], 1, "second read acked early");
    await_count(EV_RTRN + 0, 2, "first of two reads");
    release_after_ack(1, 2);
    await_count(EV_RTRN + 1, 2, "second of two reads");

    // flush behind a pending read and a busy write buffer
    raise_miss(0, 1'b0, 32'h5555_aaa0, 3'd0, 2'd1, 4'b1011, '0);
    release_after_ack(0, 3);
    fwr_before      = ev_cnt[EV_FWR];
    wbuffer_empty_i = 1'b0;
    flush_asked     = 1'b1;
    flush_i         = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    await_count(EV_RTRN + 0, 3, "read pending at flush");
    repeat (6) @(negedge clk_i);
    check(ev_cnt[EV_FWR], fwr_before, "sweep started with write buffer busy");
    wbuffer_empty_i = 1'b1;
    await_count(EV_SWEEP, 2, "requested sweep");
    repeat (10) @(negedge clk_i);
    check(ev_cnt[EV_FACK], 1, "flush ack count");

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/dcache_missunit.sv
`default_nettype none
`include "dcache_defs.svh"

module dcache_missunit (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // cache management
  input  logic                                             flush_i,
  output logic                                             flush_ack_o,
  output logic                                             miss_o,
  input  logic                                             wbuffer_empty_i,
  // miss ports, last one is the write port
  input  logic [`DCACHE_NUM_PORTS-1:0]                     miss_req_i,
  output logic [`DCACHE_NUM_PORTS-1:0]                     miss_ack_o,
  input  logic [`DCACHE_NUM_PORTS-1:0]                     miss_nc_i,
  input  logic [`DCACHE_NUM_PORTS-1:0]                     miss_we_i,
  input  logic [`DCACHE_NUM_PORTS-1:0][63:0]               miss_wdata_i,
  input  dcache_geom_pkg::paddr_t  [`DCACHE_NUM_PORTS-1:0] miss_paddr_i,
  input  dcache_geom_pkg::way_oh_t [`DCACHE_NUM_PORTS-1:0] miss_vld_bits_i,
  input  dcache_geom_pkg::size_t   [`DCACHE_NUM_PORTS-1:0] miss_size_i,
  input  dcache_geom_pkg::tid_t    [`DCACHE_NUM_PORTS-1:0] miss_id_i,
  output logic [`DCACHE_NUM_PORTS-1:0]                     miss_rtrn_vld_o,
  output dcache_geom_pkg::tid_t                            miss_rtrn_id_o,
  // cache memory write port
  output logic                                             wr_cl_vld_o,
  output logic                                             wr_cl_nc_o,
  output dcache_geom_pkg::way_oh_t                         wr_cl_we_o,
  output dcache_geom_pkg::tag_t                            wr_cl_tag_o,
  output dcache_geom_pkg::set_idx_t                        wr_cl_idx_o,
  output dcache_geom_pkg::offset_t                         wr_cl_off_o,
  output dcache_geom_pkg::line_t                           wr_cl_data_o,
  output dcache_geom_pkg::way_oh_t                         wr_vld_bits_o,
  // memory side
  input  logic                                             mem_rtrn_vld_i,
  input  dcache_mem_pkg::mem_rtrn_t                        mem_rtrn_i,
  output logic                                             mem_req_o,
  input  logic                                             mem_ack_i,
  output dcache_mem_pkg::mem_req_t                         mem_data_o
);
  import dcache_geom_pkg::*;

  logic                          mshr_vld;
  logic                          alloc;
  logic                          load_ack;
  logic                          flush_en;
  set_idx_t                      flush_idx;
  way_t                          repl_way;
  logic [`DCACHE_PORT_WIDTH-1:0] mshr_port;

  miss_if miss_bus ();

  miss_port_arbiter i_arbiter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .miss_req_i      (miss_req_i),
    .miss_we_i       (miss_we_i),
    .miss_nc_i       (miss_nc_i),
    .miss_paddr_i    (miss_paddr_i),
    .miss_wdata_i    (miss_wdata_i),
    .miss_size_i     (miss_size_i),
    .miss_id_i       (miss_id_i),
    .miss_vld_bits_i (miss_vld_bits_i),
    .arb             (miss_bus.arb)
  );

  refill_mshr i_mshr (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bus           (miss_bus.ctrl),
    .alloc_i       (alloc),
    .load_ack_i    (load_ack),
    .flush_en_i    (flush_en),
    .flush_idx_i   (flush_idx),
    .mem_rtrn_i    (mem_rtrn_i),
    .mshr_vld_o    (mshr_vld),
    .repl_way_o    (repl_way),
    .mshr_port_o   (mshr_port),
    .wr_cl_vld_o   (wr_cl_vld_o),
    .wr_cl_nc_o    (wr_cl_nc_o),
    .wr_cl_we_o    (wr_cl_we_o),
    .wr_cl_tag_o   (wr_cl_tag_o),
    .wr_cl_idx_o   (wr_cl_idx_o),
    .wr_cl_off_o   (wr_cl_off_o),
    .wr_cl_data_o  (wr_cl_data_o),
    .wr_vld_bits_o (wr_vld_bits_o)
  );

  miss_ctrl_fsm i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .flush_ack_o     (flush_ack_o),
    .miss_o          (miss_o),
    .wbuffer_empty_i (wbuffer_empty_i),
    .bus             (miss_bus.ctrl),
    .mshr_vld_i      (mshr_vld),
    .repl_way_i      (repl_way),
    .mshr_port_i     (mshr_port),
    .alloc_o         (alloc),
    .load_ack_o      (load_ack),
    .flush_en_o      (flush_en),
    .flush_idx_o     (flush_idx),
    .miss_ack_o      (miss_ack_o),
    .miss_rtrn_vld_o (miss_rtrn_vld_o),
    .miss_rtrn_id_o  (miss_rtrn_id_o),
    .mem_req_o       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .mem_data_o      (mem_data_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_i      (mem_rtrn_i)
  );

endmodule

`default_nettype wire

// File: verilog/miss_ctrl_fsm.sv
`default_nettype none
`include "dcache_defs.svh"

module miss_ctrl_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  output logic                          flush_ack_o,
  output logic                          miss_o,
  input  logic                          wbuffer_empty_i,
  miss_if.ctrl                          bus,
  input  logic                          mshr_vld_i,
  input  dcache_geom_pkg::way_t         repl_way_i,
  input  logic [`DCACHE_PORT_WIDTH-1:0] mshr_port_i,
  output logic                          alloc_o,
  output logic                          load_ack_o,
  output logic                          flush_en_o,
  output dcache_geom_pkg::set_idx_t     flush_idx_o,
  output logic [`DCACHE_NUM_PORTS-1:0]  miss_ack_o,
  output logic [`DCACHE_NUM_PORTS-1:0]  miss_rtrn_vld_o,
  output dcache_geom_pkg::tid_t         miss_rtrn_id_o,
  output logic                          mem_req_o,
  input  logic                          mem_ack_i,
  output dcache_mem_pkg::mem_req_t      mem_data_o,
  input  logic                          mem_rtrn_vld_i,
  input  dcache_mem_pkg::mem_rtrn_t     mem_rtrn_i
);
  import dcache_geom_pkg::*;
  import dcache_mem_pkg::*;

  typedef enum logic [2:0] {IDLE, DRAIN, FLUSH, STORE_WAIT, LOAD_WAIT} state_e;

  state_e     state_d, state_q;
  set_idx_t   cnt_d, cnt_q;
  logic       flush_pend_d, flush_pend_q;
  logic       flush_done;
  mem_rtype_e req_type;
  logic       store_sent, store_ack, store_ok;
  logic [$clog2(`DCACHE_MAX_STORES+1)-1:0] stores_d, stores_q;

  ////////////////////////////////////////////////////////////
  // flush sweep and memory request

  assign cnt_d       = (flush_en_o) ? cnt_q + 1'b1 : '0;
  assign flush_done  = (cnt_q == set_idx_t'(`DCACHE_NUM_SETS-1));
  assign flush_idx_o = cnt_q;

  assign mem_data_o = '{rtype: req_type, nc: bus.nc, way: repl_way_i, tid: bus.id,
                        size: bus.size, paddr: paddr_size_align(bus.paddr, bus.size),
                        data: bus.wdata};

  always_comb begin : p_ack
    miss_ack_o               = '0;
    miss_ack_o[bus.port_idx] = mem_req_o & mem_ack_i;
  end

  // count a miss only for cacheable reads
  assign miss_o = alloc_o & ~bus.nc;

  ////////////////////////////////////////////////////////////
  // returns and stores in flight

  always_comb begin : p_rtrn
    load_ack_o      = 1'b0;
    store_ack       = 1'b0;
    miss_rtrn_vld_o = '0;
    if (mem_rtrn_vld_i) begin
      case (mem_rtrn_i.rtype)
        RTRN_LOAD_ACK: begin
          if (mshr_vld_i) begin
            load_ack_o                   = 1'b1;
            miss_rtrn_vld_o[mshr_port_i] = 1'b1;
          end
        end
        default: begin
          // store acks go to the write port
          if (stores_q != '0) begin
            store_ack                               = 1'b1;
            miss_rtrn_vld_o[`DCACHE_NUM_PORTS-1] = 1'b1;
          end
        end
      endcase
    end
  end

  assign miss_rtrn_id_o = mem_rtrn_i.tid;
  assign store_sent     = mem_req_o & mem_ack_i & (req_type == MEM_STORE_REQ);
  assign store_ok       = (stores_q < `DCACHE_MAX_STORES);
  assign stores_d       = stores_q + store_sent - store_ack;

  ////////////////////////////////////////////////////////////
  // control FSM

  always_comb begin : p_fsm
    state_d        = state_q;
    flush_pend_d   = flush_pend_q;
    flush_ack_o    = 1'b0;
    flush_en_o     = 1'b0;
    mem_req_o      = 1'b0;
    req_type       = MEM_LOAD_REQ;
    alloc_o        = 1'b0;
    bus.lock       = 1'b0;
    bus.mask_reads = mshr_vld_i;
    case (state_q)
      IDLE: begin
        if (flush_i || flush_pend_q) begin
          flush_pend_d = 1'b1;
          state_d      = (wbuffer_empty_i && !mshr_vld_i) ? FLUSH : DRAIN;
        end else if (bus.vld && bus.we) begin
          // stores pass straight through
          if (store_ok) begin
            mem_req_o = 1'b1;
            req_type  = MEM_STORE_REQ;
            if (!mem_ack_i) begin
              state_d = STORE_WAIT;
            end
          end
        end else if (bus.vld && (!mshr_vld_i || load_ack_o)) begin
          mem_req_o = 1'b1;
          alloc_o   = mem_ack_i;
          if (!mem_ack_i) begin
            state_d = LOAD_WAIT;
          end
        end
      end
      // hold the selection until memory takes it
      STORE_WAIT: begin
        bus.lock  = 1'b1;
        mem_req_o = 1'b1;
        req_type  = MEM_STORE_REQ;
        if (mem_ack_i) begin
          state_d = IDLE;
        end
      end
      LOAD_WAIT: begin
        bus.lock  = 1'b1;
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          alloc_o = 1'b1;
          state_d = IDLE;
        end
      end
      // stores only, wait for the read and the write buffer
      DRAIN: begin
        bus.mask_reads = 1'b1;
        if (bus.vld && store_ok) begin
          mem_req_o = 1'b1;
          req_type  = MEM_STORE_REQ;
        end
        if (wbuffer_empty_i && !mshr_vld_i) begin
          state_d = IDLE;
        end
      end
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          flush_ack_o  = flush_pend_q;
          flush_pend_d = 1'b0;
          state_d      = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // reset starts with a sweep
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q      <= FLUSH;
      cnt_q        <= '0;
      flush_pend_q <= 1'b0;
      stores_q     <= '0;
    end else begin
      state_q      <= state_d;
      cnt_q        <= cnt_d;
      flush_pend_q <= flush_pend_d;
      stores_q     <= stores_d;
    end
  end

  store_count_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    stores_q <= `DCACHE_MAX_STORES)
    else $error("too many stores in flight");

endmodule

`default_nettype wire

// File: verilog/refill_mshr.sv
`default_nettype none
`include "dcache_defs.svh"

module refill_mshr (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  miss_if.ctrl                          bus,
  input  logic                          alloc_i,
  input  logic                          load_ack_i,
  input  logic                          flush_en_i,
  input  dcache_geom_pkg::set_idx_t     flush_idx_i,
  input  dcache_mem_pkg::mem_rtrn_t     mem_rtrn_i,
  output logic                          mshr_vld_o,
  output dcache_geom_pkg::way_t         repl_way_o,
  output logic [`DCACHE_PORT_WIDTH-1:0] mshr_port_o,
  output logic                          wr_cl_vld_o,
  output logic                          wr_cl_nc_o,
  output dcache_geom_pkg::way_oh_t      wr_cl_we_o,
  output dcache_geom_pkg::tag_t         wr_cl_tag_o,
  output dcache_geom_pkg::set_idx_t     wr_cl_idx_o,
  output dcache_geom_pkg::offset_t      wr_cl_off_o,
  output dcache_geom_pkg::line_t        wr_cl_data_o,
  output dcache_geom_pkg::way_oh_t      wr_vld_bits_o
);
  import dcache_geom_pkg::*;

  // one outstanding read
  logic                          mshr_vld_q;
  paddr_t                        mshr_paddr_q;
  tid_t                          mshr_id_q;
  logic                          mshr_nc_q;
  way_t                          mshr_way_q;
  logic [`DCACHE_PORT_WIDTH-1:0] mshr_port_q;

  logic [7:0] lfsr_q;
  way_t       inv_way;
  logic       all_valid;
  logic       cl_write_en;

  ////////////////////////////////////////////////////////////
  // way replacement

  // first invalid way of the selected set
  always_comb begin : p_inv_way
    inv_way = '0;
    for (int w = `DCACHE_NUM_WAYS-1; w >= 0; w--) begin
      if (!bus.vld_bits[w]) begin
        inv_way = w[`DCACHE_WAY_WIDTH-1:0];
      end
    end
  end

  assign all_valid  = &bus.vld_bits;
  // set full, evict a pseudo-random way
  assign repl_way_o = (all_valid) ? lfsr_q[`DCACHE_WAY_WIDTH-1:0] : inv_way;

  // x^8+x^6+x^5+x^4+1, steps only when it picked the way
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q <= 8'hff;
    end else if (alloc_i && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  ////////////////////////////////////////////////////////////
  // MSHR

  // alloc wins over a load ack in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_mshr_vld
    if (!rst_ni) begin
      mshr_vld_q <= 1'b0;
    end else if (alloc_i) begin
      mshr_vld_q <= 1'b1;
    end else if (load_ack_i) begin
      mshr_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : p_mshr_data
    if (alloc_i) begin
      mshr_paddr_q <= bus.paddr;
      mshr_id_q    <= bus.id;
      mshr_nc_q    <= bus.nc;
      mshr_way_q   <= repl_way_o;
      mshr_port_q  <= bus.port_idx;
    end
  end

  assign mshr_vld_o  = mshr_vld_q;
  assign mshr_port_o = mshr_port_q;

  ////////////////////////////////////////////////////////////
  // cacheline write port

  // non-cacheable returns leave the cache alone
  assign cl_write_en   = load_ack_i & ~mshr_nc_q;

  // flush clears a whole set
  assign wr_cl_we_o    = (flush_en_i)  ? '1 :
                         (cl_write_en) ? way_bin2oh(mshr_way_q) :
                                         '0;
  assign wr_vld_bits_o = (!flush_en_i && cl_write_en) ? way_bin2oh(mshr_way_q) : '0;
  assign wr_cl_vld_o   = load_ack_i | (|wr_cl_we_o);
  assign wr_cl_nc_o    = mshr_nc_q;
  assign wr_cl_idx_o   = (flush_en_i) ? flush_idx_i : addr_idx(mshr_paddr_q);
  assign wr_cl_tag_o   = addr_tag(mshr_paddr_q);
  assign wr_cl_off_o   = mshr_paddr_q[`DCACHE_OFFSET_WIDTH-1:0];
  assign wr_cl_data_o  = mem_rtrn_i.data;

  // returned line belongs to the read held here
  load_tid_match : assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_ack_i |-> (mem_rtrn_i.tid == mshr_id_q))
    else $error("load return tid does not match the MSHR");

endmodule

`default_nettype wire

// File: verilog/miss_port_arbiter.sv
`default_nettype none
`include "dcache_defs.svh"

module miss_port_arbiter (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic [`DCACHE_NUM_PORTS-1:0]                    miss_req_i,
  input  logic [`DCACHE_NUM_PORTS-1:0]                    miss_we_i,
  input  logic [`DCACHE_NUM_PORTS-1:0]                    miss_nc_i,
  input  dcache_geom_pkg::paddr_t [`DCACHE_NUM_PORTS-1:0] miss_paddr_i,
  input  logic [`DCACHE_NUM_PORTS-1:0][63:0]              miss_wdata_i,
  input  dcache_geom_pkg::size_t  [`DCACHE_NUM_PORTS-1:0] miss_size_i,
  input  dcache_geom_pkg::tid_t   [`DCACHE_NUM_PORTS-1:0] miss_id_i,
  input  dcache_geom_pkg::way_oh_t [`DCACHE_NUM_PORTS-1:0] miss_vld_bits_i,
  miss_if.arb                                             arb
);

  logic [`DCACHE_NUM_PORTS-1:0]  req_masked_d, req_masked_q;
  logic [`DCACHE_PORT_WIDTH-1:0] port_sel;

  // locked: hold last mask, else drop reads when asked
  assign req_masked_d = (arb.lock)       ? req_masked_q :
                        (arb.mask_reads) ? (miss_req_i & miss_we_i) :
                                           miss_req_i;

  // fixed priority, lowest index wins
  always_comb begin : p_select
    port_sel = '0;
    for (int k = `DCACHE_NUM_PORTS-1; k >= 0; k--) begin
      if (req_masked_d[k]) begin
        port_sel = k[`DCACHE_PORT_WIDTH-1:0];
      end
    end
  end

  assign arb.vld      = |req_masked_d;
  assign arb.port_idx = port_sel;
  // fields of the selected port
  assign arb.we       = miss_we_i[port_sel];
  assign arb.nc       = miss_nc_i[port_sel];
  assign arb.paddr    = miss_paddr_i[port_sel];
  assign arb.wdata    = miss_wdata_i[port_sel];
  assign arb.size     = miss_size_i[port_sel];
  assign arb.id       = miss_id_i[port_sel];
  assign arb.vld_bits = miss_vld_bits_i[port_sel];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_mask_reg
    if (!rst_ni) begin
      req_masked_q <= '0;
    end else begin
      req_masked_q <= req_masked_d;
    end
  end

  // stores only ever come from the last port
  only_last_port_writes : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (miss_req_i[`DCACHE_NUM_PORTS-2:0] & miss_we_i[`DCACHE_NUM_PORTS-2:0]) == '0)
    else $error("store request on a read port");

endmodule

`default_nettype wire

// File: verilog/miss_if.sv
`default_nettype none
`include "dcache_defs.svh"

interface miss_if;
  import dcache_geom_pkg::*;

  // the winning miss, driven by the arbiter
  logic                          vld;
  logic [`DCACHE_PORT_WIDTH-1:0] port_idx;
  logic                          we;
  logic                          nc;
  paddr_t                        paddr;
  logic [63:0]                   wdata;
  size_t                         size;
  tid_t                          id;
  // valid bits of the set, seen at lookup
  way_oh_t                       vld_bits;

  // control back from the FSM
  logic                          lock;
  logic                          mask_reads;

  modport arb (
    output vld, port_idx, we, nc, paddr, wdata, size, id, vld_bits,
    input  lock, mask_reads
  );

  modport ctrl (
    input  vld, port_idx, we, nc, paddr, wdata, size, id, vld_bits,
    output lock, mask_reads
  );

endinterface

`default_nettype wire

// File: verilog/dcache_mem_pkg.sv
`default_nettype none

package dcache_mem_pkg;
  import dcache_geom_pkg::*;

  // request kinds towards memory
  typedef enum logic {
    MEM_LOAD_REQ  = 1'b0,
    MEM_STORE_REQ = 1'b1
  } mem_rtype_e;

  // return kinds from memory
  typedef enum logic {
    RTRN_LOAD_ACK  = 1'b0,
    RTRN_STORE_ACK = 1'b1
  } rtrn_type_e;

  typedef struct packed {
    mem_rtype_e  rtype;
    logic        nc;
    // refill way picked for a load
    way_t        way;
    tid_t        tid;
    size_t       size;
    paddr_t      paddr;
    logic [63:0] data;
  } mem_req_t;

  // a load ack always carries the whole line
  typedef struct packed {
    rtrn_type_e rtype;
    tid_t       tid;
    line_t      data;
  } mem_rtrn_t;

  // clear the address bits below the access size
  function automatic paddr_t paddr_size_align(paddr_t paddr, size_t size);
    paddr_t res;
    res = paddr;
    case (size)
      3'b001:  res[0]   = 1'b0;
      3'b010:  res[1:0] = 2'b00;
      3'b011:  res[2:0] = 3'b000;
      default: res      = paddr;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

// File: verilog/dcache_geom_pkg.sv
`default_nettype none
`include "dcache_defs.svh"

package dcache_geom_pkg;

  // physical address and the fields cut from it
  typedef logic [`DCACHE_PADDR_WIDTH-1:0]  paddr_t;
  typedef logic [`DCACHE_TAG_WIDTH-1:0]    tag_t;
  typedef logic [`DCACHE_INDEX_WIDTH-1:0]  set_idx_t;
  typedef logic [`DCACHE_OFFSET_WIDTH-1:0] offset_t;

  // way number, and one bit per way
  typedef logic [`DCACHE_WAY_WIDTH-1:0]    way_t;
  typedef logic [`DCACHE_NUM_WAYS-1:0]     way_oh_t;

  typedef logic [8*`DCACHE_LINE_BYTES-1:0] line_t;
  typedef logic [`DCACHE_TID_WIDTH-1:0]    tid_t;
  // log2 of the access size in bytes
  typedef logic [2:0]                      size_t;

  function automatic tag_t addr_tag(paddr_t paddr);
    return paddr[`DCACHE_PADDR_WIDTH-1 -: `DCACHE_TAG_WIDTH];
  endfunction

  function automatic set_idx_t addr_idx(paddr_t paddr);
    return paddr[`DCACHE_OFFSET_WIDTH +: `DCACHE_INDEX_WIDTH];
  endfunction

  function automatic way_oh_t way_bin2oh(way_t way);
    way_oh_t oh;
    oh      = '0;
    oh[way] = 1'b1;
    return oh;
  endfunction

endpackage

`default_nettype wire

// File: verilog/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DCACHE_NUM_WAYS    4
`define DCACHE_NUM_SETS    16
`define DCACHE_LINE_BYTES  16
`define DCACHE_PADDR_WIDTH 32

// field widths of a physical address
`define DCACHE_OFFSET_WIDTH $clog2(`DCACHE_LINE_BYTES)
`define DCACHE_INDEX_WIDTH  $clog2(`DCACHE_NUM_SETS)
`define DCACHE_TAG_WIDTH    (`DCACHE_PADDR_WIDTH-`DCACHE_INDEX_WIDTH-`DCACHE_OFFSET_WIDTH)
`define DCACHE_WAY_WIDTH    $clog2(`DCACHE_NUM_WAYS)

// miss ports, the last port only issues stores
`define DCACHE_NUM_PORTS  3
`define DCACHE_PORT_WIDTH $clog2(`DCACHE_NUM_PORTS)

// memory transactions
`define DCACHE_TID_WIDTH  2
`define DCACHE_MAX_STORES 4

`endif
